//--- rv_mem_wb_reg.sv
`timescale 1ns/1ps

module rv_mem_wb_reg
  import rv_pkg::*;
#(
  parameter int XLEN = 32
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              in_valid,
  output logic              in_ready,
  input  res_src_e          in_res_src,
  input  logic [31:0]       in_instr,
  input  logic [REG_AW-1:0] in_rd,
  input  logic              in_reg_write,
  input  logic [XLEN-1:0]   in_alu_result,
  input  logic [XLEN-1:0]   in_ld_data,
  input  logic [XLEN-1:0]   in_pc_plus4,
  input  logic [XLEN-1:0]   in_jb_target,
  input  logic [XLEN-1:0]   in_csr_rdata,
  input  logic [XLEN-1:0]   in_m_result,
  input  logic [2:0]        in_funct3,
  input  logic [XLEN-1:0]   in_rs1_data,
  input  logic [XLEN-1:0]   in_rs2_data,
  input  logic [2*XLEN-1:0] in_product,
  input  logic              in_trap,
  rv_wb_if.src              wb
);

  logic accept;

  // Slot is free when empty or when its bundle leaves this cycle
  assign in_ready = !wb.valid || wb.ready;
  assign accept   = in_valid && in_ready;

  // Occupancy flag
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb.valid <= 1'b0;
    end else if (accept) begin
      wb.valid <= 1'b1;
    end else if (wb.ready) begin
      wb.valid <= 1'b0;
    end
  end

  // Bundle payload, loaded only on acceptance
  always_ff @(posedge clk) begin
    if (accept) begin
      wb.res_src    <= in_res_src;
      wb.instr      <= in_instr;
      wb.rd         <= in_rd;
      wb.reg_write  <= in_reg_write;
      wb.alu_result <= in_alu_result;
      wb.ld_data    <= in_ld_data;
      wb.pc_plus4   <= in_pc_plus4;
      wb.jb_target  <= in_jb_target;
      wb.csr_rdata  <= in_csr_rdata;
      wb.m_result   <= in_m_result;
      wb.funct3     <= in_funct3;
      wb.rs1_data   <= in_rs1_data;
      wb.rs2_data   <= in_rs2_data;
      wb.product    <= in_product;
      wb.trap       <= in_trap;
    end
  end

  // A stalled bundle stays put until write-back takes it
  a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
    wb.valid && !wb.ready |=> wb.valid && $stable({wb.res_src, wb.instr, wb.rd,
      wb.reg_write, wb.trap, wb.funct3, wb.alu_result, wb.ld_data, wb.pc_plus4,
      wb.jb_target, wb.csr_rdata, wb.m_result, wb.rs1_data, wb.rs2_data, wb.product}));

endmodule

//--- rv_mul_sign_fix.sv
`timescale 1ns/1ps

module rv_mul_sign_fix
  import rv_pkg::*;
#(
  parameter int XLEN = 32
) (
  input  logic [2*XLEN-1:0] product,
  input  logic [XLEN-1:0]   rs1_data,
  input  logic [XLEN-1:0]   rs2_data,
  input  mul_op_e           op,
  output logic [XLEN-1:0]   result
);

  logic [XLEN-1:0] prod_lo;
  logic [XLEN-1:0] prod_hi;
  logic            rs1_neg;
  logic            rs2_neg;
  logic [XLEN-1:0] corr_rs1;
  logic [XLEN-1:0] corr_rs2;

  // Halves of the unsigned product
  assign prod_lo = product[XLEN-1:0];
  assign prod_hi = product[2*XLEN-1:XLEN];

  // Operand signs
  assign rs1_neg = rs1_data[XLEN-1];
  assign rs2_neg = rs2_data[XLEN-1];

  // A negative rs1 read as unsigned adds rs2 * 2^XLEN to the product
  assign corr_rs1 = rs1_neg ? rs2_data : '0;
  // Likewise a negative rs2 adds rs1 * 2^XLEN
  assign corr_rs2 = rs2_neg ? rs1_data : '0;

  always_comb begin
    case (op)
      // Low half is sign-independent
      MUL: begin
        result = prod_lo;
      end
      // Both operands signed
      MULH: begin
        result = prod_hi - corr_rs1 - corr_rs2;
      end
      // Only rs1 signed
      MULHSU: begin
        result = prod_hi - corr_rs1;
      end
      // Both unsigned, nothing to fix
      MULHU: begin
        result = prod_hi;
      end
      // Divider ops bypass this block in write-back
      default: begin
        result = prod_lo;
      end
    endcase
  end

endmodule

//--- rv_pkg.sv
package rv_pkg;

  // Register index width for the 32-entry integer file
  localparam int REG_AW = 5;

  // EBREAK instruction word
  localparam logic [31:0] I_EBREAK = 32'h0010_0073;

  // Write-back result source
  // Codes 6 and 7 are unused and give a zero result
  typedef enum logic [2:0] {
    RES_ALU  = 3'd0,
    RES_LOAD = 3'd1,
    RES_PC4  = 3'd2,
    RES_JB   = 3'd3,
    RES_CSR  = 3'd4,
    RES_MEXT = 3'd5
  } res_src_e;

  // M extension operation, same encoding as funct3
  // Bit 2 set selects a divider result
  typedef enum logic [2:0] {
    MUL    = 3'd0,
    MULH   = 3'd1,
    MULHSU = 3'd2,
    MULHU  = 3'd3,
    DIV    = 3'd4,
    DIVU   = 3'd5,
    REM    = 3'd6,
    REMU   = 3'd7
  } mul_op_e;

  // Reason the write-back stage stopped
  typedef enum logic [1:0] {
    HALT_NONE   = 2'd0,
    HALT_EBREAK = 2'd1,
    HALT_TRAP   = 2'd2
  } halt_e;

endpackage

//--- rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile
  import rv_pkg::*;
#(
  parameter int XLEN = 32
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              we,
  input  logic [REG_AW-1:0] waddr,
  input  logic [XLEN-1:0]   wdata,
  input  logic [REG_AW-1:0] raddr,
  output logic [XLEN-1:0]   rdata
);

  localparam int NREGS = 1 << REG_AW;

  // x0 has no storage
  logic [XLEN-1:0] regs [1:NREGS-1];

  // Write port, x0 writes dropped
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 1; i < NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // Combinational read, x0 is hardwired zero
  always_comb begin
    if (raddr == '0) begin
      rdata = '0;
    end else begin
      rdata = regs[raddr];
    end
  end

  // Write address from write-back must be resolved on every write
  a_waddr_known: assert property (@(posedge clk) disable iff (!rst_n)
    we |-> !$isunknown(waddr));

endmodule

//--- rv_wb_if.sv
`timescale 1ns/1ps

interface rv_wb_if
  import rv_pkg::*;
#(
  parameter int XLEN = 32
) ();

  // Handshake
  logic                valid;
  logic                ready;

  // Control fields
  res_src_e            res_src;
  logic [31:0]         instr;
  logic [REG_AW-1:0]   rd;
  logic                reg_write;
  logic                trap;
  logic [2:0]          funct3;

  // Candidate results
  logic [XLEN-1:0]     alu_result;
  logic [XLEN-1:0]     ld_data;
  logic [XLEN-1:0]     pc_plus4;
  logic [XLEN-1:0]     jb_target;
  logic [XLEN-1:0]     csr_rdata;
  logic [XLEN-1:0]     m_result;

  // Multiply operands and raw unsigned product
  logic [XLEN-1:0]     rs1_data;
  logic [XLEN-1:0]     rs2_data;
  logic [2*XLEN-1:0]   product;

  // Pipeline register side drives the bundle
  modport src (
    output valid, res_src, instr, rd, reg_write, trap, funct3,
    output alu_result, ld_data, pc_plus4, jb_target, csr_rdata, m_result,
    output rs1_data, rs2_data, product,
    input  ready
  );

  // Write-back side consumes it and drives ready
  modport snk (
    input  valid, res_src, instr, rd, reg_write, trap, funct3,
    input  alu_result, ld_data, pc_plus4, jb_target, csr_rdata, m_result,
    input  rs1_data, rs2_data, product,
    output ready
  );

endinterface

//--- rv_wb_stage.sv
`timescale 1ns/1ps

module rv_wb_stage
  import rv_pkg::*;
#(
  parameter int XLEN = 32
) (
  input  logic              clk,
  input  logic              rst_n,
  rv_wb_if.snk              wb,
  output logic [XLEN-1:0]   rd_data,
  output logic [REG_AW-1:0] rd_addr,
  output logic              rd_we,
  output logic              retired,
  output logic              ebreak,
  output logic              trap
);

  halt_e           halt_q;
  logic [XLEN-1:0] mul_result;
  logic [XLEN-1:0] m_ext_result;
  logic            is_ebreak;

  // Late sign correction of the multiply product
  rv_mul_sign_fix #(
    .XLEN(XLEN)
  ) i_mul_sign_fix (
    .product (wb.product),
    .rs1_data(wb.rs1_data),
    .rs2_data(wb.rs2_data),
    .op      (mul_op_e'(wb.funct3)),
    .result  (mul_result)
  );

  // Divider results arrive finished, funct3 bit 2 picks them
  assign m_ext_result = wb.funct3[2] ? wb.m_result : mul_result;

  // Final result mux
  always_comb begin
    case (wb.res_src)
      RES_ALU:  rd_data = wb.alu_result;
      RES_LOAD: rd_data = wb.ld_data;
      RES_PC4:  rd_data = wb.pc_plus4;
      RES_JB:   rd_data = wb.jb_target;
      RES_CSR:  rd_data = wb.csr_rdata;
      RES_MEXT: rd_data = m_ext_result;
      default:  rd_data = '0;
    endcase
  end

  // Instruction retires on the handshake
  assign retired = wb.valid && wb.ready;

  // Accept only while running
  assign wb.ready = (halt_q == HALT_NONE);

  assign is_ebreak = (wb.instr == I_EBREAK);

  // Register write, suppressed for a trapping instruction
  assign rd_addr = wb.rd;
  assign rd_we   = retired && wb.reg_write && !wb.trap;

  // Halt FSM, entered on the edge that ends the retire cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      halt_q <= HALT_NONE;
    end else begin
      case (halt_q)
        HALT_NONE: begin
          // Trap wins over EBREAK
          if (retired && wb.trap) begin
            halt_q <= HALT_TRAP;
          end else if (retired && is_ebreak) begin
            halt_q <= HALT_EBREAK;
          end
        end
        // Sticky until reset
        default: begin
          halt_q <= halt_q;
        end
      endcase
    end
  end

  // Status is up in the retire cycle and held once halted
  assign trap   = (retired && wb.trap) || (halt_q == HALT_TRAP);
  assign ebreak = (retired && is_ebreak && !wb.trap) || (halt_q == HALT_EBREAK);

  // No retire once a halt has been flagged
  a_no_retire_after_halt: assert property (@(posedge clk) disable iff (!rst_n)
    (ebreak || trap) |=> !retired);

  // Halt causes are exclusive
  a_halt_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    !(ebreak && trap));

endmodule

//--- rv_wb_top.sv
`timescale 1ns/1ps

module rv_wb_top
  import rv_pkg::*;
#(
  parameter int XLEN = 32
) (
  input  logic              clk,
  input  logic              rst_n,

  // Incoming bundle from MEM
  input  logic              in_valid,
  output logic              in_ready,
  input  res_src_e          in_res_src,
  input  logic [31:0]       in_instr,
  input  logic [REG_AW-1:0] in_rd,
  input  logic              in_reg_write,
  input  logic [XLEN-1:0]   in_alu_result,
  input  logic [XLEN-1:0]   in_ld_data,
  input  logic [XLEN-1:0]   in_pc_plus4,
  input  logic [XLEN-1:0]   in_jb_target,
  input  logic [XLEN-1:0]   in_csr_rdata,
  input  logic [XLEN-1:0]   in_m_result,
  input  logic [2:0]        in_funct3,
  input  logic [XLEN-1:0]   in_rs1_data,
  input  logic [XLEN-1:0]   in_rs2_data,
  input  logic [2*XLEN-1:0] in_product,
  input  logic              in_trap,

  // Register file read port
  input  logic [REG_AW-1:0] raddr,
  output logic [XLEN-1:0]   rdata,

  // Write-back result
  output logic [XLEN-1:0]   wb_data,
  output logic [REG_AW-1:0] wb_rd,
  output logic              wb_we,

  // Status
  output logic              retired,
  output logic              ebreak,
  output logic              trap
);

  // MEM/WB bundle
  rv_wb_if #(.XLEN(XLEN)) wb_bus ();

  rv_mem_wb_reg #(
    .XLEN(XLEN)
  ) i_mem_wb_reg (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .in_res_src   (in_res_src),
    .in_instr     (in_instr),
    .in_rd        (in_rd),
    .in_reg_write (in_reg_write),
    .in_alu_result(in_alu_result),
    .in_ld_data   (in_ld_data),
    .in_pc_plus4  (in_pc_plus4),
    .in_jb_target (in_jb_target),
    .in_csr_rdata (in_csr_rdata),
    .in_m_result  (in_m_result),
    .in_funct3    (in_funct3),
    .in_rs1_data  (in_rs1_data),
    .in_rs2_data  (in_rs2_data),
    .in_product   (in_product),
    .in_trap      (in_trap),
    .wb           (wb_bus.src)
  );

  rv_wb_stage #(
    .XLEN(XLEN)
  ) i_wb_stage (
    .clk    (clk),
    .rst_n  (rst_n),
    .wb     (wb_bus.snk),
    .rd_data(wb_data),
    .rd_addr(wb_rd),
    .rd_we  (wb_we),
    .retired(retired),
    .ebreak (ebreak),
    .trap   (trap)
  );

  // Write port fed straight from write-back
  rv_regfile #(
    .XLEN(XLEN)
  ) i_regfile (
    .clk  (clk),
    .rst_n(rst_n),
    .we   (wb_we),
    .waddr(wb_rd),
    .wdata(wb_data),
    .raddr(raddr),
    .rdata(rdata)
  );

endmodule

//--- tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS  = 10,
  parameter int RST_CYCLES = 4
) (
  input  logic rst_req,
  output logic clk,
  output logic rst_n
);

  logic por_n;

  // Free-running clock
  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Power-on reset, released on a falling edge
  initial begin
    por_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    por_n = 1'b1;
  end

  // Testbench can pull reset again at any time
  assign rst_n = por_n && !rst_req;

endmodule

//--- tb_rv_wb.sv
`timescale 1ns/1ps

module tb_rv_wb
  import rv_pkg::*;
();

  localparam int XLEN       = 32;
  localparam int RST_CYCLES = 4;
  localparam logic [31:0] NOP = 32'h0000_0013;

  // Bundle plus read-back address and expected outcome
  typedef struct packed {
    logic              rst_before;
    res_src_e          src;
    logic [31:0]       instr;
    logic [REG_AW-1:0] rd;
    logic              reg_write;
    logic [XLEN-1:0]   alu;
    logic [XLEN-1:0]   ld;
    logic [XLEN-1:0]   pc4;
    logic [XLEN-1:0]   jb;
    logic [XLEN-1:0]   csr;
    logic [XLEN-1:0]   mres;
    logic [2:0]        funct3;
    logic [XLEN-1:0]   rs1;
    logic [XLEN-1:0]   rs2;
    logic [2*XLEN-1:0] product;
    logic              trap;
    logic [REG_AW-1:0] raddr;
    logic [XLEN-1:0]   exp_wb;
    halt_e             exp_halt;
  } entry_t;

  integer            seed = 64;
  entry_t            tbl[$];
  string             names[$];
  logic [XLEN-1:0]   model [32];
  logic              table_done = 1'b0;
  logic              clk;
  logic              rst_n;
  logic              rst_req;
  entry_t            cur;
  logic              in_valid;
  logic              in_ready;
  logic [REG_AW-1:0] raddr;
  logic [XLEN-1:0]   rdata;
  logic [XLEN-1:0]   wb_data;
  logic [REG_AW-1:0] wb_rd;
  logic              wb_we;
  logic              retired;
  logic              ebreak;
  logic              trap;

  tb_clk_gen #(
    .PERIOD_NS (10),
    .RST_CYCLES(RST_CYCLES)
  ) i_clk_gen (
    .rst_req(rst_req),
    .clk    (clk),
    .rst_n  (rst_n)
  );

  // Bundle fields come straight from the current table row
  rv_wb_top #(
    .XLEN(XLEN)
  ) i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .in_res_src   (cur.src),
    .in_instr     (cur.instr),
    .in_rd        (cur.rd),
    .in_reg_write (cur.reg_write),
    .in_alu_result(cur.alu),
    .in_ld_data   (cur.ld),
    .in_pc_plus4  (cur.pc4),
    .in_jb_target (cur.jb),
    .in_csr_rdata (cur.csr),
    .in_m_result  (cur.mres),
    .in_funct3    (cur.funct3),
    .in_rs1_data  (cur.rs1),
    .in_rs2_data  (cur.rs2),
    .in_product   (cur.product),
    .in_trap      (cur.trap),
    .raddr        (raddr),
    .rdata        (rdata),
    .wb_data      (wb_data),
    .wb_rd        (wb_rd),
    .wb_we        (wb_we),
    .retired      (retired),
    .ebreak       (ebreak),
    .trap         (trap)
  );

  function automatic logic [XLEN-1:0] rnd();
    return $random(seed);
  endfunction

  // True product from sign- or zero-extended operands
  function automatic logic [XLEN-1:0] ref_mul(logic [2:0] op, logic [XLEN-1:0] a,
                                              logic [XLEN-1:0] b);
    logic [2*XLEN-1:0] sa;
    logic [2*XLEN-1:0] za;
    logic [2*XLEN-1:0] sb;
    logic [2*XLEN-1:0] zb;
    logic [2*XLEN-1:0] p;
    sa = {{XLEN{a[XLEN-1]}}, a};
    za = {{XLEN{1'b0}}, a};
    sb = {{XLEN{b[XLEN-1]}}, b};
    zb = {{XLEN{1'b0}}, b};
    case (op)
      3'd1:    p = sa * sb;
      3'd2:    p = sa * zb;
      default: p = za * zb;
    endcase
    return (op == 3'd0) ? p[XLEN-1:0] : p[2*XLEN-1:XLEN];
  endfunction

  function automatic logic [XLEN-1:0] m_value(entry_t e);
    return e.funct3[2] ? e.mres : ref_mul(e.funct3, e.rs1, e.rs2);
  endfunction

  function automatic logic [XLEN-1:0] expected_result(entry_t e);
    case (e.src)
      RES_ALU:  return e.alu;
      RES_LOAD: return e.ld;
      RES_PC4:  return e.pc4;
      RES_JB:   return e.jb;
      RES_CSR:  return e.csr;
      RES_MEXT: return m_value(e);
      default:  return '0;
    endcase
  endfunction

  // Which candidate field the written value came from
  function automatic res_src_e src_from_data(entry_t e, logic [XLEN-1:0] d);
    if (d == e.alu) return RES_ALU;
    if (d == e.ld) return RES_LOAD;
    if (d == e.pc4) return RES_PC4;
    if (d == e.jb) return RES_JB;
    if (d == e.csr) return RES_CSR;
    if (d == m_value(e)) return RES_MEXT;
    return res_src_e'(3'd7);
  endfunction

  function automatic halt_e halt_from_flags(logic eb, logic tr);
    if (tr) return HALT_TRAP;
    if (eb) return HALT_EBREAK;
    return HALT_NONE;
  endfunction

  task automatic stop_run();
    $display("Simulation failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_word(input string nm, input logic [XLEN-1:0] exp,
                            input logic [XLEN-1:0] act);
    if (act !== exp) begin
      $display("FAILED %s expected %h actual %h", nm, exp, act);
      stop_run();
    end
  endtask

  task automatic check_rd(input string nm, input logic [REG_AW-1:0] exp,
                          input logic [REG_AW-1:0] act);
    if (act !== exp) begin
      $display("FAILED %s expected %0d actual %0d", nm, exp, act);
      stop_run();
    end
  endtask

  task automatic check_flag(input string nm, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED %s expected %b actual %b", nm, exp, act);
      stop_run();
    end
  endtask

  task automatic check_src(input string nm, input res_src_e exp, input res_src_e act);
    if (act !== exp) begin
      $display("FAILED %s expected %s actual %s", nm, exp.name(), act.name());
      stop_run();
    end
  endtask

  task automatic check_halt(input string nm, input halt_e exp, input halt_e act);
    if (act !== exp) begin
      $display("FAILED %s expected %s actual %s", nm, exp.name(), act.name());
      stop_run();
    end
  endtask

  task automatic add_entry(input string name, input res_src_e src, input logic [2:0] f3,
                           input logic [REG_AW-1:0] rd, input logic trp,
                           input logic [31:0] instr, input logic [XLEN-1:0] a,
                           input logic [XLEN-1:0] b, input logic rst_before);
    entry_t e;
    e            = '0;
    e.rst_before = rst_before;
    e.src        = src;
    e.instr      = instr;
    e.rd         = rd;
    e.reg_write  = 1'b1;
    e.alu        = rnd();
    e.ld         = rnd();
    e.pc4        = rnd();
    e.jb         = rnd();
    e.csr        = rnd();
    e.mres       = rnd();
    e.funct3     = f3;
    e.rs1        = a;
    e.rs2        = b;
    // Raw unsigned product as the multiplier array delivers it
    e.product    = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
    e.trap       = trp;
    e.raddr      = rd;
    e.exp_wb     = expected_result(e);
    e.exp_halt   = trp ? HALT_TRAP : ((instr == I_EBREAK) ? HALT_EBREAK : HALT_NONE);
    tbl.push_back(e);
    names.push_back(name);
  endtask

  // Reset mid-run, then everything must read as fresh
  task automatic apply_reset(input string nm, input logic [REG_AW-1:0] ra);
    raddr   = ra;
    rst_req = 1'b1;
    repeat (RST_CYCLES) @(negedge clk);
    rst_req = 1'b0;
    for (int r = 0; r < 32; r++) begin
      model[r] = '0;
    end
    check_flag({nm, " reset in_ready"}, 1'b1, in_ready);
    check_flag({nm, " reset retired"}, 1'b0, retired);
    check_flag({nm, " reset wb_we"}, 1'b0, wb_we);
    check_halt({nm, " reset halt"}, HALT_NONE, halt_from_flags(ebreak, trap));
    check_word({nm, " reset read"}, '0, rdata);
  endtask

  task automatic run_entry(input string nm, input entry_t e);
    cur      = e;
    in_valid = 1'b1;
    // in_ready seen at a falling edge holds through the next rising edge
    while (!in_ready) @(negedge clk);
    @(negedge clk);
    in_valid = 1'b0;
    while (!retired) @(negedge clk);
    check_src(nm, e.src, src_from_data(e, wb_data));
    check_word(nm, e.exp_wb, wb_data);
    check_rd({nm, " wb_rd"}, e.rd, wb_rd);
    check_flag({nm, " wb_we"}, e.reg_write && !e.trap, wb_we);
    check_halt(nm, e.exp_halt, halt_from_flags(ebreak, trap));
    raddr = e.raddr;
    if (e.reg_write && !e.trap && (e.rd != '0)) begin
      model[e.rd] = e.exp_wb;
    end
    // Written value visible one cycle after retire
    @(negedge clk);
    check_word({nm, " read"}, model[e.raddr], rdata);
  endtask

  // After a halt a new bundle is taken into the slot but never retires
  task automatic check_stall(input string nm, input entry_t e);
    entry_t p;
    p        = e;
    p.trap   = 1'b0;
    p.instr  = NOP;
    p.src    = RES_ALU;
    p.alu    = rnd();
    cur      = p;
    in_valid = 1'b1;
    repeat (6) begin
      @(negedge clk);
      check_flag({nm, " stall retired"}, 1'b0, retired);
      check_halt({nm, " stall halt"}, e.exp_halt, halt_from_flags(ebreak, trap));
    end
    check_flag({nm, " stall in_ready"}, 1'b0, in_ready);
    in_valid = 1'b0;
    check_word({nm, " stall read"}, model[e.raddr], rdata);
  endtask

  initial begin : main
    entry_t e;
    cur      = '0;
    in_valid = 1'b0;
    raddr    = '0;
    rst_req  = 1'b0;
    for (int r = 0; r < 32; r++) begin
      model[r] = '0;
    end
    // Result selection
    add_entry("sel_alu", RES_ALU, 0, 1, 0, NOP, rnd(), rnd(), 0);
    add_entry("sel_load", RES_LOAD, 0, 2, 0, NOP, rnd(), rnd(), 0);
    add_entry("sel_pc4", RES_PC4, 0, 3, 0, NOP, rnd(), rnd(), 0);
    add_entry("sel_jb", RES_JB, 0, 4, 0, NOP, rnd(), rnd(), 0);
    add_entry("sel_csr", RES_CSR, 0, 5, 0, NOP, rnd(), rnd(), 0);
    add_entry("sel_mext", RES_MEXT, 0, 6, 0, NOP, rnd(), rnd(), 0);
    // Multiply correction, random and sign-edge operands
    add_entry("mul_rand", RES_MEXT, 0, 7, 0, NOP, rnd(), rnd(), 0);
    add_entry("mulh_rand", RES_MEXT, 1, 8, 0, NOP, rnd(), rnd(), 0);
    add_entry("mulhsu_rand", RES_MEXT, 2, 9, 0, NOP, rnd(), rnd(), 0);
    add_entry("mulhu_rand", RES_MEXT, 3, 10, 0, NOP, rnd(), rnd(), 0);
    add_entry("mulh_min_min", RES_MEXT, 1, 11, 0, NOP, 32'h8000_0000, 32'h8000_0000, 0);
    add_entry("mulh_m1_min", RES_MEXT, 1, 12, 0, NOP, 32'hffff_ffff, 32'h8000_0000, 0);
    add_entry("mulhsu_min_max", RES_MEXT, 2, 13, 0, NOP, 32'h8000_0000, 32'hffff_ffff, 0);
    add_entry("mulhu_max_max", RES_MEXT, 3, 14, 0, NOP, 32'hffff_ffff, 32'hffff_ffff, 0);
    add_entry("mul_m1_pos", RES_MEXT, 0, 15, 0, NOP, 32'hffff_ffff, 32'h7fff_ffff, 0);
    // Divider results pass through
    add_entry("div", RES_MEXT, 4, 16, 0, NOP, rnd(), rnd(), 0);
    add_entry("divu", RES_MEXT, 5, 17, 0, NOP, rnd(), rnd(), 0);
    add_entry("rem", RES_MEXT, 6, 18, 0, NOP, rnd(), rnd(), 0);
    add_entry("remu", RES_MEXT, 7, 19, 0, NOP, rnd(), rnd(), 0);
    add_entry("x0_write", RES_ALU, 0, 0, 0, NOP, rnd(), rnd(), 0);
    // Halts, each followed by a reset that reads a written register
    add_entry("trap", RES_ALU, 0, 20, 1, NOP, rnd(), rnd(), 0);
    add_entry("after_trap", RES_LOAD, 0, 1, 0, NOP, rnd(), rnd(), 1);
    add_entry("ebreak", RES_PC4, 0, 21, 0, I_EBREAK, rnd(), rnd(), 0);
    add_entry("after_ebreak", RES_CSR, 0, 21, 0, NOP, rnd(), rnd(), 1);
    table_done = 1'b1;
    wait (rst_n);
    @(negedge clk);
    for (int i = 0; i < tbl.size(); i++) begin
      e = tbl[i];
      if (e.rst_before) begin
        apply_reset(names[i], e.raddr);
      end
      run_entry(names[i], e);
      if (e.exp_halt != HALT_NONE) begin
        check_stall(names[i], e);
      end
    end
    $display("Simulation completed successfully");
    $finish;
  end

  // Budget of 20 cycles per table row plus the power-on reset
  initial begin : watchdog
    wait (table_done);
    repeat (tbl.size() * 20 + RST_CYCLES) @(posedge clk);
    $display("Timeout: the test sequence did not finish in the allowed number of cycles");
    stop_run();
  end

endmodule

//--- verilog.f
rv_pkg.sv
rv_wb_if.sv
rv_mem_wb_reg.sv
rv_mul_sign_fix.sv
rv_wb_stage.sv
rv_regfile.sv
rv_wb_top.sv
tb_clk_gen.sv
tb_rv_wb.sv
